/* include/cache_config.svh */
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

//////////////////////////////////////////////////
// Cache geometry
//////////////////////////////////////////////////

// Word select within a line, eight words
`define CACHE_OFFSET_WIDTH 3

// Set index, 64 sets
`define CACHE_INDEX_WIDTH 6

// Word address bits left over for the tag
`define CACHE_TAG_WIDTH (30 - `CACHE_OFFSET_WIDTH - `CACHE_INDEX_WIDTH)

// Number of sets per way
`define CACHE_DEPTH (1 << `CACHE_INDEX_WIDTH)

// Words per cache line
`define CACHE_LINE_WORDS (1 << `CACHE_OFFSET_WIDTH)

`endif

/* hdl/cache_pkg.sv */
`include "cache_config.svh"

package cache_pkg;

    //////////////////////////////////////////////////
    // Shared cache types
    //////////////////////////////////////////////////

    // One data word
    typedef logic [31:0] word_t;

    // Per-byte write strobes, bit 0 for the low byte
    typedef logic [3:0] byte_en_t;

    // Way number within a set
    typedef enum logic {
        WAY0 = 1'b0,
        WAY1 = 1'b1
    } way_t;

    // Stored line tag
    typedef logic [`CACHE_TAG_WIDTH-1:0] tag_t;

endpackage

/* hdl/cache_way.sv */
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_way
    import cache_pkg::*;
(
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           enable,
    input  logic [`CACHE_INDEX_WIDTH-1:0]  index,
    input  logic [`CACHE_OFFSET_WIDTH-1:0] word_sel,
    input  tag_t                           tag_in,
    input  word_t                          data_in,
    input  logic                           valid_in,
    input  byte_en_t                       byte_w_en,
    input  logic                           write,
    input  logic                           fill,
    output logic                           tag_match,
    output logic                           valid,
    output logic                           dirty,
    output tag_t                           tag_out,
    output word_t                          data_out
);

    //////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////

    // One tag per set
    tag_t tag_mem [`CACHE_DEPTH];

    // Line state bits, one per set
    logic [`CACHE_DEPTH-1:0] valid_bits;
    logic [`CACHE_DEPTH-1:0] dirty_bits;

    // All words of all lines, addressed by {index, word_sel}
    word_t data_mem [`CACHE_DEPTH*`CACHE_LINE_WORDS];

    // Flat word address into the data array
    logic [`CACHE_INDEX_WIDTH+`CACHE_OFFSET_WIDTH-1:0] word_addr;

    // Write strobe for this way
    logic wr_en;

    // Stored word with the enabled bytes replaced
    word_t wr_word;

    assign word_addr = {index, word_sel};
    assign wr_en     = enable & write;

    //////////////////////////////////////////////////
    // Combinational lookup
    //////////////////////////////////////////////////

    assign tag_out  = tag_mem[index];
    assign valid    = valid_bits[index];
    assign dirty    = dirty_bits[index];
    assign data_out = data_mem[word_addr];

    // Raw tag compare, valid is qualified at the top
    assign tag_match = (tag_out == tag_in);

    // Byte merge of new data over the current word
    always_comb begin
        wr_word = data_out;
        for (int b = 0; b < 4; b++) begin
            if (byte_w_en[b]) begin
                wr_word[8*b +: 8] = data_in[8*b +: 8];
            end
        end
    end

    //////////////////////////////////////////////////
    // Writes
    //////////////////////////////////////////////////

    // Data word and tag, visible on the next cycle
    always_ff @(posedge clk) begin
        if (wr_en) begin
            data_mem[word_addr] <= wr_word;
            // Tag only changes when a new line comes in
            if (fill) begin
                tag_mem[index] <= tag_in;
            end
        end
    end

    // Line state
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (wr_en) begin
            if (fill) begin
                // Fresh line from memory is clean
                valid_bits[index] <= valid_in;
                dirty_bits[index] <= 1'b0;
            end else begin
                // Processor store marks the line for write-back
                dirty_bits[index] <= 1'b1;
            end
        end
    end

endmodule

/* hdl/victim_select.sv */
`timescale 1ns/1ps
`include "cache_config.svh"

module victim_select
    import cache_pkg::*;
(
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          enable,
    input  logic                          cmp,
    input  logic                          write,
    input  logic [`CACHE_INDEX_WIDTH-1:0] index,
    input  logic                          valid0,
    input  logic                          valid1,
    input  way_t                          hit_way,
    input  logic                          hit,
    output way_t                          victim,
    output way_t                          victim_latched
);

    // Most recently used way of each set, 0 means way 0
    logic [`CACHE_DEPTH-1:0] mru_bits;

    // Access strobes
    logic victim_rd;
    logic fill_wr;
    logic cmp_hit;

    assign victim_rd = enable & ~cmp & ~write;
    assign fill_wr   = enable & ~cmp & write;
    assign cmp_hit   = enable & cmp & hit;

    // Invalid way first, lowest number wins
    // Full set takes the way that was not used last
    always_comb begin
        if (!valid0) begin
            victim = WAY0;
        end else if (!valid1) begin
            victim = WAY1;
        end else begin
            victim = way_t'(~mru_bits[index]);
        end
    end

    // Victim held from the eviction read through all fills
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            victim_latched <= WAY0;
        end else if (victim_rd) begin
            victim_latched <= victim;
        end
    end

    // MRU follows hits and fills
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mru_bits <= '0;
        end else if (cmp_hit) begin
            mru_bits[index] <= hit_way;
        end else if (fill_wr) begin
            mru_bits[index] <= victim_latched;
        end
    end

endmodule

/* hdl/cache_2ways.sv */
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_2ways
    import cache_pkg::*;
(
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           enable,
    input  logic [`CACHE_INDEX_WIDTH-1:0]  index,
    input  logic [`CACHE_OFFSET_WIDTH-1:0] word_sel,
    input  tag_t                           tag_in,
    input  word_t                          data_in,
    input  logic                           valid_in,
    input  byte_en_t                       byte_w_en,
    input  logic                           cmp,
    input  logic                           write,
    output logic                           hit,
    output logic                           dirty,
    output tag_t                           tag_out,
    output word_t                          data_out,
    output logic                           valid_out
);

    // Per-way lookup results
    logic  match0, match1;
    logic  valid0, valid1;
    logic  dirty0, dirty1;
    tag_t  tag0, tag1;
    word_t data0, data1;

    // Qualified hits
    logic hit0, hit1;
    logic way_hit;
    way_t hit_way;

    // Victim choice, current and held
    way_t victim;
    way_t victim_latched;

    // Per-way controls
    logic en0, en1;
    logic write0, write1;
    logic fill;

    // Way that drives the outputs
    way_t out_way;

    //////////////////////////////////////////////////
    // Hit detection
    //////////////////////////////////////////////////

    assign hit0    = match0 & valid0;
    assign hit1    = match1 & valid1;
    assign way_hit = hit0 | hit1;
    assign hit_way = hit0 ? WAY0 : WAY1;

    //////////////////////////////////////////////////
    // Enable and write steering
    //////////////////////////////////////////////////

    // Compare reaches both ways, fill only the held victim
    assign fill = ~cmp;
    assign en0  = enable & (cmp | (victim_latched == WAY0));
    assign en1  = enable & (cmp | (victim_latched == WAY1));

    // Compare write lands only in the way that hit
    assign write0 = write & (cmp ? hit0 : 1'b1);
    assign write1 = write & (cmp ? hit1 : 1'b1);

    cache_way way0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .enable    (en0),
        .index     (index),
        .word_sel  (word_sel),
        .tag_in    (tag_in),
        .data_in   (data_in),
        .valid_in  (valid_in),
        .byte_w_en (byte_w_en),
        .write     (write0),
        .fill      (fill),
        .tag_match (match0),
        .valid     (valid0),
        .dirty     (dirty0),
        .tag_out   (tag0),
        .data_out  (data0)
    );

    cache_way way1 (
        .clk       (clk),
        .arst_n    (arst_n),
        .enable    (en1),
        .index     (index),
        .word_sel  (word_sel),
        .tag_in    (tag_in),
        .data_in   (data_in),
        .valid_in  (valid_in),
        .byte_w_en (byte_w_en),
        .write     (write1),
        .fill      (fill),
        .tag_match (match1),
        .valid     (valid1),
        .dirty     (dirty1),
        .tag_out   (tag1),
        .data_out  (data1)
    );

    victim_select victim_sel (
        .clk            (clk),
        .arst_n         (arst_n),
        .enable         (enable),
        .cmp            (cmp),
        .write          (write),
        .index          (index),
        .valid0         (valid0),
        .valid1         (valid1),
        .hit_way        (hit_way),
        .hit            (way_hit),
        .victim         (victim),
        .victim_latched (victim_latched)
    );

    //////////////////////////////////////////////////
    // Output muxing
    //////////////////////////////////////////////////

    // Hit way on compare, current victim on eviction read
    assign out_way = cmp ? hit_way : (write ? victim_latched : victim);

    assign tag_out  = (out_way == WAY1) ? tag1 : tag0;
    assign data_out = (out_way == WAY1) ? data1 : data0;

    // State bits of the selected way, quiet when idle
    assign hit       = enable & cmp & way_hit;
    assign valid_out = enable & (cmp ? way_hit : ((out_way == WAY1) ? valid1 : valid0));
    assign dirty     = enable & (~cmp | way_hit) & ((out_way == WAY1) ? dirty1 : dirty0);

endmodule

/* bench/tb_cache_2ways.sv */
`timescale 1ns/1ps
`include "cache_config.svh"

module tb_cache_2ways
    import cache_pkg::*;
();

    // Words per pattern record and record capacity
    localparam int FIELDS  = 14;
    localparam int MAX_REC = 64;

    // DUT inputs
    logic                           clk;
    logic                           arst_n;
    logic                           enable;
    logic [`CACHE_INDEX_WIDTH-1:0]  index;
    logic [`CACHE_OFFSET_WIDTH-1:0] word_sel;
    tag_t                           tag_in;
    word_t                          data_in;
    logic                           valid_in;
    byte_en_t                       byte_w_en;
    logic                           cmp;
    logic                           write;

    // DUT outputs
    logic  hit;
    logic  dirty;
    tag_t  tag_out;
    word_t data_out;
    logic  valid_out;

    // Raw pattern words as loaded from the file
    logic [31:0] pat_mem [FIELDS*MAX_REC];

    // Bookkeeping
    int n_rec;
    int pass_cnt;
    int fail_cnt;
    int fails_before;
    int grp_err;
    int cur_grp;
    int base;
    logic [4:0] mask;

    always #4 clk = ~clk;

    cache_2ways dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .enable    (enable),
        .index     (index),
        .word_sel  (word_sel),
        .tag_in    (tag_in),
        .data_in   (data_in),
        .valid_in  (valid_in),
        .byte_w_en (byte_w_en),
        .cmp       (cmp),
        .write     (write),
        .hit       (hit),
        .dirty     (dirty),
        .tag_out   (tag_out),
        .data_out  (data_out),
        .valid_out (valid_out)
    );

    // Log one wrong output value
    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act, input int rec);
        $display("FAIL record %0d %s expected %h actual %h", rec, name, exp, act);
        fail_cnt++;
        grp_err++;
    endtask

    task automatic close_group(input int grp);
        $display("Test group %0d finished with %0d mismatches", grp, grp_err);
        grp_err = 0;
    endtask

    //////////////////////////////////////////////////
    // Stimulus and checks
    //////////////////////////////////////////////////

    initial begin
        clk       = 1'b0;
        arst_n    = 1'b0;
        enable    = 1'b0;
        index     = '0;
        word_sel  = '0;
        tag_in    = '0;
        data_in   = '0;
        valid_in  = 1'b0;
        byte_w_en = '0;
        cmp       = 1'b0;
        write     = 1'b0;
        pass_cnt  = 0;
        fail_cnt  = 0;
        grp_err   = 0;
        n_rec     = 0;
        $readmemh("bench/cache_patterns.txt", pat_mem);
        // Records end at the first blank or unknown group field
        while (n_rec < MAX_REC && !$isunknown(pat_mem[n_rec*FIELDS])
               && pat_mem[n_rec*FIELDS] != 32'h0) begin
            n_rec++;
        end
        if (n_rec == 0) begin
            $display("No pattern records could be loaded");
            fail_cnt++;
        end
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        cur_grp = (n_rec > 0) ? int'(pat_mem[0]) : 0;
        for (int r = 0; r < n_rec; r++) begin
            base = r * FIELDS;
            @(posedge clk);
            enable    <= pat_mem[base+1][2];
            cmp       <= pat_mem[base+1][1];
            write     <= pat_mem[base+1][0];
            index     <= pat_mem[base+2][`CACHE_INDEX_WIDTH-1:0];
            word_sel  <= pat_mem[base+3][`CACHE_OFFSET_WIDTH-1:0];
            tag_in    <= pat_mem[base+4][`CACHE_TAG_WIDTH-1:0];
            data_in   <= pat_mem[base+5];
            valid_in  <= pat_mem[base+6][0];
            byte_w_en <= pat_mem[base+7][3:0];
            // Outputs settle mid-cycle before the write edge
            @(negedge clk);
            if (int'(pat_mem[base]) != cur_grp) begin
                close_group(cur_grp);
                cur_grp = int'(pat_mem[base]);
            end
            mask = pat_mem[base+8][4:0];
            fails_before = fail_cnt;
            if (mask[0] && hit !== pat_mem[base+9][0]) begin
                report_mismatch("hit", pat_mem[base+9], 32'(hit), r);
            end
            if (mask[1] && valid_out !== pat_mem[base+10][0]) begin
                report_mismatch("valid_out", pat_mem[base+10], 32'(valid_out), r);
            end
            if (mask[2] && dirty !== pat_mem[base+11][0]) begin
                report_mismatch("dirty", pat_mem[base+11], 32'(dirty), r);
            end
            if (mask[3] && tag_out !== pat_mem[base+12][`CACHE_TAG_WIDTH-1:0]) begin
                report_mismatch("tag_out", pat_mem[base+12], 32'(tag_out), r);
            end
            if (mask[4] && data_out !== pat_mem[base+13]) begin
                report_mismatch("data_out", pat_mem[base+13], data_out, r);
            end
            pass_cnt += $countones(mask) - (fail_cnt - fails_before);
        end
        if (n_rec > 0) begin
            close_group(cur_grp);
        end
        $display("Checks passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // Watchdog at twice the expected run length
    initial begin
        #1;
        #((n_rec * 8 + 4 * 8) * 2);
        $display("Run timed out before all pattern records were applied");
        $display("Result: FAILED");
        $finish;
    end

endmodule

/* bench/cache_patterns.txt */
// grp ctl(en,cmp,wr) idx ws tag data valid_in byte_en mask(data,tag,dirty,valid,hit)
// exp_hit exp_valid exp_dirty exp_tag exp_data
1 6 05 0 000123 00000000 0 0 03 0 0 0 000000 00000000
1 6 2A 0 000000 00000000 0 0 03 0 0 0 000000 00000000
1 4 05 0 000000 00000000 0 0 06 0 0 0 000000 00000000
2 4 05 0 000000 00000000 0 0 06 0 0 0 000000 00000000
2 5 05 0 000123 A0000000 1 F 01 0 0 0 000000 00000000
2 5 05 1 000123 A0000001 1 F 01 0 0 0 000000 00000000
2 5 05 2 000123 A0000002 1 F 01 0 0 0 000000 00000000
2 5 05 3 000123 A0000003 1 F 01 0 0 0 000000 00000000
2 5 05 4 000123 A0000004 1 F 01 0 0 0 000000 00000000
2 5 05 5 000123 A0000005 1 F 01 0 0 0 000000 00000000
2 5 05 6 000123 A0000006 1 F 01 0 0 0 000000 00000000
2 5 05 7 000123 A0000007 1 F 01 0 0 0 000000 00000000
2 6 05 0 000123 00000000 0 0 1F 1 1 0 000123 A0000000
2 6 05 3 000123 00000000 0 0 1F 1 1 0 000123 A0000003
2 6 05 7 000123 00000000 0 0 1F 1 1 0 000123 A0000007
2 4 05 0 000000 00000000 0 0 06 0 0 0 000000 00000000
2 5 05 0 000456 B0000000 1 F 01 0 0 0 000000 00000000
2 5 05 1 000456 B0000001 1 F 01 0 0 0 000000 00000000
2 6 05 1 000456 00000000 0 0 1F 1 1 0 000456 B0000001
2 6 05 7 000123 00000000 0 0 1F 1 1 0 000123 A0000007
3 7 05 3 000123 12345678 0 5 01 1 0 0 000000 00000000
3 6 05 3 000123 00000000 0 0 1F 1 1 1 000123 A0340078
3 7 05 0 000789 FFFFFFFF 0 F 01 0 0 0 000000 00000000
3 6 05 0 000123 00000000 0 0 1F 1 1 1 000123 A0000000
3 6 05 0 000456 00000000 0 0 1F 1 1 0 000456 B0000000
4 6 05 1 000123 00000000 0 0 1F 1 1 1 000123 A0000001
4 4 05 1 000000 00000000 0 0 1F 0 1 0 000456 B0000001
4 5 05 0 000ABC C0000000 1 F 01 0 0 0 000000 00000000
4 6 05 0 000ABC 00000000 0 0 1F 1 1 0 000ABC C0000000
4 6 05 3 000123 00000000 0 0 1F 1 1 1 000123 A0340078
4 6 05 0 000456 00000000 0 0 03 0 0 0 000000 00000000
5 6 05 0 000ABC 00000000 0 0 1F 1 1 0 000ABC C0000000
5 4 05 3 000000 00000000 0 0 1F 0 1 1 000123 A0340078
5 5 05 3 000DEF D0000003 1 F 01 0 0 0 000000 00000000
5 6 05 3 000DEF 00000000 0 0 1F 1 1 0 000DEF D0000003
6 3 05 3 000DEF 00000000 0 F 07 0 0 0 000000 00000000
6 1 05 3 000111 00000000 1 F 07 0 0 0 000000 00000000
6 2 05 3 000DEF 00000000 0 0 07 0 0 0 000000 00000000
6 6 05 3 000DEF 00000000 0 0 1F 1 1 0 000DEF D0000003

/* project.f */
+incdir+include
hdl/cache_pkg.sv
hdl/cache_way.sv
hdl/victim_select.sv
hdl/cache_2ways.sv
bench/tb_cache_2ways.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the cache array testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    --top-module tb_cache_2ways \
    -f project.f \
    -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Result: FAILED" sim.log; then
    echo "Simulation failed"
    exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation passed"
